// File: hw/tank_pkg.sv
package tank_pkg;

    //////////////////////////////////////////////////
    // Pixel and button types
    //////////////////////////////////////////////////

    typedef logic [9:0] coord_t;
    typedef logic [7:0] color_t;
    typedef logic [4:0] btns_t;

    typedef enum logic [1:0] {
        DIR_UP,
        DIR_DOWN,
        DIR_LEFT,
        DIR_RIGHT
    } dir_t;

    typedef enum logic {
        BULLET_IDLE,
        BULLET_FLYING
    } bullet_state_t;

    // One-hot codes where only an exact match counts
    localparam btns_t BTN_UP    = 5'b00001;
    localparam btns_t BTN_DOWN  = 5'b00010;
    localparam btns_t BTN_LEFT  = 5'b00100;
    localparam btns_t BTN_RIGHT = 5'b01000;
    localparam btns_t BTN_FIRE  = 5'b10000;

    //////////////////////////////////////////////////
    // Field geometry
    //////////////////////////////////////////////////

    localparam coord_t FIELD_W       = 10'd640;
    localparam coord_t FIELD_H       = 10'd480;
    localparam coord_t TANK_SIZE     = 10'd32;
    localparam coord_t BULLET_SIZE   = 10'd8;
    localparam coord_t BULLET_OFFSET = 10'd12;

    localparam int NUM_PLAYERS = 2;

    // Index 0 is player 1
    localparam coord_t [NUM_PLAYERS-1:0] START_X = {10'd530, 10'd70};
    localparam coord_t [NUM_PLAYERS-1:0] START_Y = {10'd400, 10'd50};

    // RGB332 palette
    localparam color_t [NUM_PLAYERS-1:0] TANK_COLOR = {8'h1C, 8'hE0};
    localparam color_t BULLET_COLOR = 8'hFC;
    localparam color_t BG_COLOR     = 8'h00;

endpackage

// File: hw/move_pacer.sv
`timescale 1ns/10ps

module move_pacer #(
    parameter int unsigned TANK_TICK_CYCLES   = 100000,
    parameter int unsigned BULLET_TICK_CYCLES = 25000
) (
    input  logic clk_25m,
    input  logic rst_n,
    output logic tank_step,
    output logic bullet_step
);

    localparam int unsigned MAX_TICKS = (TANK_TICK_CYCLES > BULLET_TICK_CYCLES) ?
                                        TANK_TICK_CYCLES : BULLET_TICK_CYCLES;
    localparam int CNT_W = $clog2(MAX_TICKS) + 1;

    logic [1:0] step;

    // Index 0 paces the tanks, index 1 the bullets
    for (genvar i = 0; i < 2; i++)
    begin : g_tick
        localparam int unsigned PERIOD = (i == 0) ? TANK_TICK_CYCLES : BULLET_TICK_CYCLES;

        logic [CNT_W-1:0] cnt;
        logic             pulse;

        always_ff @(posedge clk_25m or negedge rst_n)
        begin
            if (!rst_n)
            begin
                cnt   <= '0;
                pulse <= 1'b0;
            end
            else if (cnt == CNT_W'(PERIOD - 1))
            begin
                cnt   <= '0;
                pulse <= 1'b1;
            end
            else
            begin
                cnt   <= cnt + 1'b1;
                pulse <= 1'b0;
            end
        end

        assign step[i] = pulse;

        a_single_pulse: assert property (@(posedge clk_25m) disable iff (!rst_n)
            pulse |=> !pulse);
    end

    assign tank_step   = step[0];
    assign bullet_step = step[1];

endmodule

// File: hw/tank_unit.sv
`timescale 1ns/10ps

module tank_unit #(
    parameter tank_pkg::coord_t START_X = '0,
    parameter tank_pkg::coord_t START_Y = '0
) (
    input  logic             clk_25m,
    input  logic             rst_n,
    input  tank_pkg::btns_t  btns,
    input  logic             tank_step,
    input  logic             bullet_step,
    input  tank_pkg::coord_t pixel_x,
    input  tank_pkg::coord_t pixel_y,
    output logic             tank_hit,
    output logic             bullet_hit
);

    localparam tank_pkg::coord_t TANK_MAX_X   = tank_pkg::FIELD_W - tank_pkg::TANK_SIZE;
    localparam tank_pkg::coord_t TANK_MAX_Y   = tank_pkg::FIELD_H - tank_pkg::TANK_SIZE;
    localparam tank_pkg::coord_t BULLET_MAX_X = tank_pkg::FIELD_W - tank_pkg::BULLET_SIZE;
    localparam tank_pkg::coord_t BULLET_MAX_Y = tank_pkg::FIELD_H - tank_pkg::BULLET_SIZE;

    tank_pkg::dir_t          tank_dir;
    tank_pkg::dir_t          btn_dir;
    logic                    btn_move;
    logic                    tank_blocked;
    tank_pkg::coord_t        tank_x;
    tank_pkg::coord_t        tank_y;
    logic                    fire;
    tank_pkg::bullet_state_t bullet_state;
    tank_pkg::dir_t          bullet_dir;
    tank_pkg::coord_t        bullet_x;
    tank_pkg::coord_t        bullet_y;
    logic                    bullet_exit;

    //////////////////////////////////////////////////
    // Button decode
    //////////////////////////////////////////////////

    always_comb
    begin
        btn_move = 1'b1;
        btn_dir  = tank_dir;
        case (btns)
            tank_pkg::BTN_UP:    btn_dir = tank_pkg::DIR_UP;
            tank_pkg::BTN_DOWN:  btn_dir = tank_pkg::DIR_DOWN;
            tank_pkg::BTN_LEFT:  btn_dir = tank_pkg::DIR_LEFT;
            tank_pkg::BTN_RIGHT: btn_dir = tank_pkg::DIR_RIGHT;
            default:             btn_move = 1'b0;
        endcase
    end

    assign fire = (btns == tank_pkg::BTN_FIRE) && (bullet_state == tank_pkg::BULLET_IDLE);

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
            tank_dir <= tank_pkg::DIR_UP;
        else if (btn_move)
            tank_dir <= btn_dir;
    end

    //////////////////////////////////////////////////
    // Tank movement clamped to the field
    //////////////////////////////////////////////////

    always_comb
    begin
        case (btn_dir)
            tank_pkg::DIR_UP:   tank_blocked = (tank_y == '0);
            tank_pkg::DIR_DOWN: tank_blocked = (tank_y >= TANK_MAX_Y);
            tank_pkg::DIR_LEFT: tank_blocked = (tank_x == '0);
            default:            tank_blocked = (tank_x >= TANK_MAX_X);
        endcase
    end

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tank_x <= START_X;
            tank_y <= START_Y;
        end
        else if (tank_step && btn_move && !tank_blocked)
        begin
            case (btn_dir)
                tank_pkg::DIR_UP:   tank_y <= tank_y - 1'b1;
                tank_pkg::DIR_DOWN: tank_y <= tank_y + 1'b1;
                tank_pkg::DIR_LEFT: tank_x <= tank_x - 1'b1;
                default:            tank_x <= tank_x + 1'b1;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Bullet
    //////////////////////////////////////////////////

    // Next step would cross the field edge
    always_comb
    begin
        case (bullet_dir)
            tank_pkg::DIR_UP:   bullet_exit = (bullet_y == '0);
            tank_pkg::DIR_DOWN: bullet_exit = (bullet_y >= BULLET_MAX_Y);
            tank_pkg::DIR_LEFT: bullet_exit = (bullet_x == '0);
            default:            bullet_exit = (bullet_x >= BULLET_MAX_X);
        endcase
    end

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
            bullet_state <= tank_pkg::BULLET_IDLE;
        else
        begin
            case (bullet_state)
                tank_pkg::BULLET_IDLE:
                    if (fire)
                        bullet_state <= tank_pkg::BULLET_FLYING;
                default:
                    if (bullet_step && bullet_exit)
                        bullet_state <= tank_pkg::BULLET_IDLE;
            endcase
        end
    end

    // Spawn centered on the tank, heading where the tank faces
    always_ff @(posedge clk_25m)
    begin
        if (fire)
        begin
            bullet_x   <= tank_x + tank_pkg::BULLET_OFFSET;
            bullet_y   <= tank_y + tank_pkg::BULLET_OFFSET;
            bullet_dir <= tank_dir;
        end
        else if (bullet_state == tank_pkg::BULLET_FLYING && bullet_step && !bullet_exit)
        begin
            case (bullet_dir)
                tank_pkg::DIR_UP:   bullet_y <= bullet_y - 1'b1;
                tank_pkg::DIR_DOWN: bullet_y <= bullet_y + 1'b1;
                tank_pkg::DIR_LEFT: bullet_x <= bullet_x - 1'b1;
                default:            bullet_x <= bullet_x + 1'b1;
            endcase
        end
    end

    // Overlap with the current pixel
    assign tank_hit = (pixel_x >= tank_x) && (pixel_x < tank_x + tank_pkg::TANK_SIZE) &&
                      (pixel_y >= tank_y) && (pixel_y < tank_y + tank_pkg::TANK_SIZE);

    assign bullet_hit = (bullet_state == tank_pkg::BULLET_FLYING) &&
                        (pixel_x >= bullet_x) && (pixel_x < bullet_x + tank_pkg::BULLET_SIZE) &&
                        (pixel_y >= bullet_y) && (pixel_y < bullet_y + tank_pkg::BULLET_SIZE);

    a_bullet_in_field: assert property (@(posedge clk_25m) disable iff (!rst_n)
        (bullet_state == tank_pkg::BULLET_FLYING) |->
            (bullet_x <= BULLET_MAX_X) && (bullet_y <= BULLET_MAX_Y));

    a_tank_clamped: assert property (@(posedge clk_25m) disable iff (!rst_n)
        (tank_x <= TANK_MAX_X) && (tank_y <= TANK_MAX_Y));

endmodule

// File: hw/sprite_mixer.sv
`timescale 1ns/10ps

module sprite_mixer (
    input  logic                            clk_25m,
    input  logic                            rst_n,
    input  logic [tank_pkg::NUM_PLAYERS-1:0] tank_hit,
    input  logic [tank_pkg::NUM_PLAYERS-1:0] bullet_hit,
    output tank_pkg::color_t                screen_data
);

    tank_pkg::color_t pixel_color;
    logic             palette_ok;

    // Bullets on top, then lowest player index, then background
    always_comb
    begin
        pixel_color = tank_pkg::BG_COLOR;
        for (int i = tank_pkg::NUM_PLAYERS - 1; i >= 0; i--)
        begin
            if (tank_hit[i])
                pixel_color = tank_pkg::TANK_COLOR[i];
        end
        if (|bullet_hit)
            pixel_color = tank_pkg::BULLET_COLOR;
    end

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
            screen_data <= tank_pkg::BG_COLOR;
        else
            screen_data <= pixel_color;
    end

    always_comb
    begin
        palette_ok = (screen_data == tank_pkg::BG_COLOR) ||
                     (screen_data == tank_pkg::BULLET_COLOR);
        for (int p = 0; p < tank_pkg::NUM_PLAYERS; p++)
        begin
            if (screen_data == tank_pkg::TANK_COLOR[p])
                palette_ok = 1'b1;
        end
    end

    a_palette_only: assert property (@(posedge clk_25m) disable iff (!rst_n)
        palette_ok);

endmodule

// File: hw/game_scene.sv
`timescale 1ns/10ps

module game_scene #(
    parameter int unsigned TANK_TICK_CYCLES   = 100000,
    parameter int unsigned BULLET_TICK_CYCLES = 25000
) (
    input  logic             clk_25m,
    input  logic             rst_n,
    input  tank_pkg::coord_t pixel_x,
    input  tank_pkg::coord_t pixel_y,
    input  tank_pkg::btns_t  player1_btns,
    input  tank_pkg::btns_t  player2_btns,
    output tank_pkg::color_t screen_data
);

    logic                             tank_step;
    logic                             bullet_step;
    tank_pkg::btns_t                  player_btns [tank_pkg::NUM_PLAYERS];
    logic [tank_pkg::NUM_PLAYERS-1:0] tank_hit;
    logic [tank_pkg::NUM_PLAYERS-1:0] bullet_hit;

    assign player_btns[0] = player1_btns;
    assign player_btns[1] = player2_btns;

    move_pacer #(
        .TANK_TICK_CYCLES   (TANK_TICK_CYCLES),
        .BULLET_TICK_CYCLES (BULLET_TICK_CYCLES)
    ) i_pacer (
        .clk_25m     (clk_25m),
        .rst_n       (rst_n),
        .tank_step   (tank_step),
        .bullet_step (bullet_step)
    );

    //////////////////////////////////////////////////
    // One tank unit per player
    //////////////////////////////////////////////////

    for (genvar i = 0; i < tank_pkg::NUM_PLAYERS; i++)
    begin : g_player
        tank_unit #(
            .START_X (tank_pkg::START_X[i]),
            .START_Y (tank_pkg::START_Y[i])
        ) i_tank (
            .clk_25m     (clk_25m),
            .rst_n       (rst_n),
            .btns        (player_btns[i]),
            .tank_step   (tank_step),
            .bullet_step (bullet_step),
            .pixel_x     (pixel_x),
            .pixel_y     (pixel_y),
            .tank_hit    (tank_hit[i]),
            .bullet_hit  (bullet_hit[i])
        );
    end

    sprite_mixer i_mixer (
        .clk_25m     (clk_25m),
        .rst_n       (rst_n),
        .tank_hit    (tank_hit),
        .bullet_hit  (bullet_hit),
        .screen_data (screen_data)
    );

endmodule

// File: sim/tb_game_scene.sv
`timescale 1ns/10ps

module tb_game_scene;

    localparam int    CLK_PERIOD  = 40;
    localparam int    RESET_TICKS = 8;
    localparam string STIM_FILE   = "sim/game_stimulus.txt";

    logic             clk_25m;
    logic             rst_n;
    tank_pkg::coord_t pixel_x;
    tank_pkg::coord_t pixel_y;
    tank_pkg::btns_t  player1_btns;
    tank_pkg::btns_t  player2_btns;
    tank_pkg::color_t screen_data;

    int     check_count;
    int     error_count;
    int     test_count;
    int     test_checks;
    int     test_errors;
    longint timeout_cycles;
    logic   timeout_ready;

    game_scene #(
        .TANK_TICK_CYCLES   (4),
        .BULLET_TICK_CYCLES (64)
    ) i_dut (
        .clk_25m      (clk_25m),
        .rst_n        (rst_n),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .player1_btns (player1_btns),
        .player2_btns (player2_btns),
        .screen_data  (screen_data)
    );

    initial
    begin
        clk_25m = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk_25m = ~clk_25m;
    end

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////

    task automatic apply_reset();
        @(negedge clk_25m);
        player1_btns = '0;
        player2_btns = '0;
        rst_n        = 1'b0;
        repeat (RESET_TICKS) @(negedge clk_25m);
        rst_n = 1'b1;
    endtask

    // Buttons are seen by exactly 'cycles' rising edges
    task automatic hold_buttons(input int b1, input int b2, input int cycles);
        player1_btns = tank_pkg::btns_t'(b1);
        player2_btns = tank_pkg::btns_t'(b2);
        repeat (cycles) @(negedge clk_25m);
        player1_btns = '0;
        player2_btns = '0;
    endtask

    task automatic probe_pixel(input int x, input int y, input int expected);
        tank_pkg::color_t exp_color;
        exp_color = tank_pkg::color_t'(expected);
        pixel_x   = tank_pkg::coord_t'(x);
        pixel_y   = tank_pkg::coord_t'(y);
        @(posedge clk_25m);
        @(negedge clk_25m);
        check_count++;
        test_checks++;
        assert (screen_data == exp_color)
        else
        begin
            $display("FAIL %0t ns: pixel (%0d,%0d) expected %h, got %h",
                     $time, x, y, exp_color, screen_data);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic close_test(input string name);
        $display("Test %s done: %0d checks, %0d failed", name, test_checks, test_errors);
        test_count++;
        test_checks = 0;
        test_errors = 0;
    endtask

    function automatic logic is_command(input string line);
        byte cmd;
        cmd = line.getc(0);
        return (cmd == "R") || (cmd == "H") || (cmd == "P") || (cmd == "T");
    endfunction

    //////////////////////////////////////////////////
    // Stimulus file
    //////////////////////////////////////////////////

    // First pass only sizes the watchdog
    task automatic size_timeout(output logic ok);
        int     fd;
        int     n;
        int     b1;
        int     b2;
        int     cycles;
        int     commands;
        longint hold_sum;
        string  line;
        hold_sum = 0;
        commands = 0;
        fd       = $fopen(STIM_FILE, "r");
        ok       = (fd != 0);
        if (ok)
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 0 && is_command(line))
                begin
                    commands++;
                    if (line.getc(0) == "H" && $sscanf(line, "H %h %h %d", b1, b2, cycles) == 3)
                        hold_sum += cycles;
                end
            end
            $fclose(fd);
        end
        timeout_cycles = hold_sum + 100 * commands;
    endtask

    task automatic run_stimulus(input int fd);
        int    n;
        int    b1;
        int    b2;
        int    cycles;
        int    x;
        int    y;
        int    color;
        string line;
        string name;
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 0 && is_command(line))
            begin
                case (line.getc(0))
                    "R": apply_reset();
                    "H":
                        if ($sscanf(line, "H %h %h %d", b1, b2, cycles) == 3)
                            hold_buttons(b1, b2, cycles);
                        else
                        begin
                            $display("Malformed hold line in stimulus file: %s", line);
                            error_count++;
                        end
                    "P":
                        if ($sscanf(line, "P %d %d %h", x, y, color) == 3)
                            probe_pixel(x, y, color);
                        else
                        begin
                            $display("Malformed probe line in stimulus file: %s", line);
                            error_count++;
                        end
                    default:
                    begin
                        n = $sscanf(line, "T %s", name);
                        close_test(name);
                    end
                endcase
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial
    begin
        int   fd;
        logic file_ok;
        rst_n         = 1'b0;
        pixel_x       = '0;
        pixel_y       = '0;
        player1_btns  = '0;
        player2_btns  = '0;
        check_count   = 0;
        error_count   = 0;
        test_count    = 0;
        test_checks   = 0;
        test_errors   = 0;
        timeout_ready = 1'b0;

        size_timeout(file_ok);
        fd = file_ok ? $fopen(STIM_FILE, "r") : 0;
        if (fd == 0)
        begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            $display("Errors found");
        end
        else
        begin
            timeout_ready = 1'b1;
            run_stimulus(fd);
            $fclose(fd);
            $display("Tests: %0d, checks: %0d, failures: %0d", test_count, check_count,
                     error_count);
            if (error_count == 0)
                $display("No errors");
            else
                $display("Errors found");
        end
        $finish;
    end

    initial
    begin
        wait (timeout_ready);
        #(timeout_cycles * CLK_PERIOD);
        $display("Simulation timed out after %0d clock cycles", timeout_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

// File: sim/game_stimulus.txt
# R: reset | H p1 p2 n: hold buttons (hex) for n cycles | T name: end of test
# P x y color: probe pixel (decimal x, y) and expect color (hex)
R
P 70 50 E0
P 101 81 E0
P 69 50 00
P 70 82 00
P 530 400 1C
P 561 431 1C
P 562 400 00
T reset_start
R
H 08 00 41
P 111 50 E0
P 80 81 E0
P 79 50 00
P 70 60 00
P 112 50 00
T move_right
R
H 04 00 400
P 0 50 E0
P 31 81 E0
P 32 50 00
T clamp_left
R
H 10 00 1
P 82 62 FC
P 89 69 FC
P 90 62 E0
P 81 69 E0
T fire_up
R
H 10 00 1
H 10 00 10
P 82 62 FC
P 89 69 FC
H 00 00 2600
P 82 22 FC
P 82 30 00
H 00 00 1500
P 82 0 00
P 82 62 E0
H 10 00 1
P 82 62 FC
P 89 69 FC
T bullet_life
R
H 08 04 881
P 290 50 E0
P 321 81 E0
P 310 400 1C
P 289 50 00
H 02 01 680
P 310 230 E0
P 321 251 E0
P 322 230 1C
P 341 261 1C
P 290 220 E0
P 289 220 00
T two_players

// File: tank_game.f
hw/tank_pkg.sv
hw/move_pacer.sv
hw/tank_unit.sv
hw/sprite_mixer.sv
hw/game_scene.sv
sim/tb_game_scene.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --top-module tb_game_scene \
    -Mdir "$build_dir" \
    -f tank_game.f
if [ $? -ne 0 ]
then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_game_scene" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]
then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

grep -q "Errors found" "$log_file"
grep_status=$?
if [ $grep_status -eq 0 ]
then
    echo "Simulation reported failures"
    exit 1
elif [ $grep_status -ne 1 ]
then
    echo "Could not read $log_file"
    exit 1
fi

echo "Simulation passed"
exit 0
